//--- design/inert_cfg.svh
`ifndef INERT_CFG_SVH
`define INERT_CFG_SVH

//////////////////////////////////////////////////
// Timing of the sensor link.
//////////////////////////////////////////////////
`define BOOT_WAIT_BITS 8    // Boot timer width. Silicon wants 16, simulation runs with 8.
`define SCLK_DIV_BITS 2     // SCLK toggles each time this many divider bits wrap.

//////////////////////////////////////////////////
// Heading integration.
//////////////////////////////////////////////////
`define CAL_SAMPLES_LOG2 3  // Calibration averages 2**3 samples.
`define IR_CORR 512         // Accumulator nudge per guardrail hit.

// Selects accumulator bits [HEAD_SHIFT+11:HEAD_SHIFT] as the heading.
`define HEAD_SHIFT 8

`endif

//--- design/inert_pkg.sv
package inert_pkg;

  //////////////////////////////////////////////////
  // Sequencer states.
  //////////////////////////////////////////////////
  typedef enum logic [2:0] {
    BOOT,       // Waiting for the sensor to finish booting.
    CFG_RATE,   // Interrupt-enable frame in flight, rate/range word goes next.
    CFG_ROUND,  // Rate/range frame in flight, rounding word goes next.
    INT_WAIT,   // Idle until the sensor reports a new sample.
    READ_H,     // Yaw high-byte read in flight.
    READ_L      // Yaw low-byte read in flight.
  } seq_state_t;

  //////////////////////////////////////////////////
  // Data words.
  //////////////////////////////////////////////////
  typedef logic [15:0] spi_word_t;         // One full SPI frame, command or response.
  typedef logic signed [15:0] yaw_rate_t;  // Raw Z-axis gyro reading.

  // Zero is the original direction and full scale is half a turn.
  typedef logic signed [11:0] heading_t;

endpackage

//--- design/spi_bus_if.sv
`timescale 1ns/1ps

interface spi_bus_if import inert_pkg::*; ();

  logic      snd;   // One-cycle request to start a frame.
  spi_word_t cmd;   // Word to shift out, valid with snd.
  logic      done;  // Level, high while the master is idle with a finished frame.
  spi_word_t resp;  // Word shifted in, valid while done is high.

  // The sequencer side issues frames.
  modport seq (
    output snd,
    output cmd,
    input  done,
    input  resp
  );

  // The master side runs them.
  modport mstr (
    input  snd,
    input  cmd,
    output done,
    output resp
  );

endinterface

//--- design/spi_mnrch.sv
`timescale 1ns/1ps
`include "inert_cfg.svh"

module spi_mnrch import inert_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  spi_bus_if.mstr    bus,
  output logic       SS_n,
  output logic       SCLK,
  output logic       MOSI,
  input  logic       MISO
);

  typedef enum logic [1:0] {IDLE, FRONT, SHIFT, BACK} mstr_state_t;

  mstr_state_t               state;      // Frame sequencing state.
  logic [`SCLK_DIV_BITS-1:0] div_cnt;    // SCLK half-period divider.
  logic                      div_wrap;   // Divider is about to roll over.
  logic [3:0]                bit_cnt;    // Falling edges seen in this frame.
  spi_word_t                 shft;       // Shared transmit and receive shift register.
  logic                      miso_smpl;  // MISO captured on the SCLK rising edge.

  assign div_wrap = &div_cnt;            // One wrap per SCLK half period.
  assign MOSI     = shft[15];            // MSB goes out first.
  assign bus.resp = shft;                // Holds the received word once the frame ends.

  //////////////////////////////////////////////////
  // Frame control.
  //////////////////////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      state    <= IDLE;
      SS_n     <= 1'b1;                  // Sensor deselected out of reset.
      SCLK     <= 1'b0;                  // Mode 0 idles low.
      bus.done <= 1'b0;                  // No frame has finished yet.
      div_cnt  <= '0;
      bit_cnt  <= '0;
    end else begin
      case (state)
        IDLE: begin
          div_cnt <= '0;                 // Start every frame at a fresh half period.
          bit_cnt <= '0;
          if (bus.snd) begin
            SS_n     <= 1'b0;            // Select drops in the cycle after snd.
            bus.done <= 1'b0;
            state    <= FRONT;
          end
        end
        FRONT: begin
          div_cnt <= div_cnt + 1'b1;     // MOSI settles for one half period before SCLK rises.
          if (div_wrap)
            state <= SHIFT;
        end
        SHIFT: begin
          div_cnt <= div_cnt + 1'b1;
          if (div_wrap) begin
            SCLK <= ~SCLK;               // Toggle on each wrap.
            if (SCLK) begin              // This wrap is a falling edge.
              bit_cnt <= bit_cnt + 1'b1;
              if (&bit_cnt)
                state <= BACK;           // Sixteenth fall ends the data phase.
            end
          end
        end
        default: begin                   // Back porch is one cycle long.
          SS_n     <= 1'b1;
          bus.done <= 1'b1;              // Rises together with SS_n.
          state    <= IDLE;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Data path.
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (state == IDLE && bus.snd)
      shft <= bus.cmd;                   // Load the outgoing word.
    else if (state == SHIFT && div_wrap && !SCLK)
      miso_smpl <= MISO;                 // Sample as SCLK rises.
    else if (state == SHIFT && div_wrap && SCLK)
      shft <= {shft[14:0], miso_smpl};   // Shift as SCLK falls, next MOSI bit appears.
  end

endmodule

//--- design/inert_seq.sv
`timescale 1ns/1ps
`include "inert_cfg.svh"

module inert_seq import inert_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      INT,
  spi_bus_if.seq    bus,
  output logic      vld,
  output yaw_rate_t yaw_rt
);

  // Configuration words, written once after boot.
  localparam spi_word_t CMD_INT_EN = 16'h0D02;  // Data-ready interrupt on INT1.
  localparam spi_word_t CMD_RATE   = 16'h1160;  // Gyro at 416 Hz, 250 deg/s range.
  localparam spi_word_t CMD_ROUND  = 16'h1440;  // Rounding on for gyro outputs.

  // Yaw register reads, the read flag is bit 15.
  localparam spi_word_t CMD_YAW_H  = 16'hA700;  // Z-axis rate, high byte.
  localparam spi_word_t CMD_YAW_L  = 16'hA600;  // Z-axis rate, low byte.

  seq_state_t                 state;      // Current state.
  seq_state_t                 nxt_state;  // Next state.
  logic [`BOOT_WAIT_BITS-1:0] boot_tmr;   // Free-running boot timer.
  logic                       boot_full;  // Timer sits at all ones.
  logic                       int_meta;   // First synchronizer stage.
  logic                       int_sync;   // INT in the clk domain.
  logic                       cap_h;      // Latch the high byte this cycle.
  logic                       cap_l;      // Assemble the full sample this cycle.
  logic                       set_vld;    // vld goes high next cycle.
  logic [7:0]                 high_byte;  // High byte held until the low byte arrives.

  //////////////////////////////////////////////////
  // Boot timer and interrupt synchronizer.
  //////////////////////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      boot_tmr <= '0;
    else
      boot_tmr <= boot_tmr + 1'b1;        // Only the BOOT state looks at it.
  end

  assign boot_full = &boot_tmr;           // First reached 2**N-1 cycles after reset.

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      int_meta <= 1'b0;
      int_sync <= 1'b0;
    end else begin
      int_meta <= INT;                    // May go metastable.
      int_sync <= int_meta;               // Safe to use two cycles after INT rises.
    end
  end

  //////////////////////////////////////////////////
  // Sample capture and vld.
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (cap_h)
      high_byte <= bus.resp[7:0];         // Only the low byte of a read response is data.
    if (cap_l)
      yaw_rt <= {high_byte, bus.resp[7:0]};
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      vld <= 1'b0;
    else
      vld <= set_vld;                     // Lines up with the new yaw_rt.
  end

  //////////////////////////////////////////////////
  // State machine.
  //////////////////////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      state <= BOOT;
    else
      state <= nxt_state;
  end

  always_comb begin
    nxt_state = state;                    // Hold by default.
    bus.snd   = 1'b0;
    bus.cmd   = CMD_INT_EN;
    cap_h     = 1'b0;
    cap_l     = 1'b0;
    set_vld   = 1'b0;
    case (state)
      BOOT: begin
        bus.cmd = CMD_INT_EN;
        if (boot_full) begin              // Sensor has had time to come up.
          bus.snd   = 1'b1;
          nxt_state = CFG_RATE;
        end
      end
      CFG_RATE: begin
        bus.cmd = CMD_RATE;
        if (bus.done) begin
          bus.snd   = 1'b1;
          nxt_state = CFG_ROUND;
        end
      end
      CFG_ROUND: begin
        bus.cmd = CMD_ROUND;
        if (bus.done) begin
          bus.snd   = 1'b1;
          nxt_state = INT_WAIT;
        end
      end
      INT_WAIT: begin
        bus.cmd = CMD_YAW_H;
        // The sensor drops INT once it sees the low-byte read, long before that frame ends.
        if (int_sync && bus.done) begin
          bus.snd   = 1'b1;
          nxt_state = READ_H;
        end
      end
      READ_H: begin
        bus.cmd = CMD_YAW_L;
        if (bus.done) begin
          cap_h     = 1'b1;               // High byte is in resp now.
          bus.snd   = 1'b1;               // Low-byte read goes out at once.
          nxt_state = READ_L;
        end
      end
      READ_L: begin
        bus.cmd = CMD_YAW_L;
        if (bus.done) begin
          cap_l     = 1'b1;
          set_vld   = 1'b1;
          nxt_state = INT_WAIT;
        end
      end
      default: nxt_state = BOOT;
    endcase
  end

endmodule

//--- design/yaw_integrator.sv
`timescale 1ns/1ps
`include "inert_cfg.svh"

module yaw_integrator import inert_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      strt_cal,
  input  logic      vld,
  input  yaw_rate_t yaw_rt,
  input  logic      moving,
  input  logic      lftIR,
  input  logic      rghtIR,
  output logic      cal_done,
  output logic      rdy,
  output heading_t  heading
);

  localparam int CAL_W = `CAL_SAMPLES_LOG2;         // Averaging depth as a power of two.
  localparam int HS    = `HEAD_SHIFT;               // Accumulator to heading scaling.
  localparam logic signed [23:0] IR_STEP = 24'(`IR_CORR);

  logic                     cal_busy;     // Calibration window is open.
  logic [CAL_W-1:0]         cal_cnt;      // Samples taken in this window.
  logic                     cal_last;     // This vld closes the window.
  logic signed [15+CAL_W:0] cal_sum;      // Running sum of calibration samples.
  logic signed [15+CAL_W:0] cal_sum_nxt;  // Sum including the current sample.
  yaw_rate_t                offset;       // Gyro zero-rate bias.
  logic signed [16:0]       rate_corr;    // Bias-free rate, one bit wider so it cannot wrap.
  logic signed [23:0]       rate_term;    // Rate contribution, gated by moving.
  logic signed [23:0]       ir_term;      // Guardrail contribution.
  logic signed [23:0]       acc;          // Integrated heading at full precision.
  logic signed [23:0]       acc_nxt;      // Accumulator after the current sample.

  //////////////////////////////////////////////////
  // Datapath.
  //////////////////////////////////////////////////
  assign cal_last    = &cal_cnt;                    // Last of 2**CAL_W samples.
  assign cal_sum_nxt = cal_sum + {{CAL_W{yaw_rt[15]}}, yaw_rt};

  assign rate_corr = {yaw_rt[15], yaw_rt} - {offset[15], offset};
  assign rate_term = moving ? {{7{rate_corr[16]}}, rate_corr} : '0;  // Stationary holds.

  // Left pushes one way, right the other, both together cancel.
  assign ir_term = (lftIR ? IR_STEP : '0) - (rghtIR ? IR_STEP : '0);

  assign acc_nxt = acc + rate_term + ir_term;

  //////////////////////////////////////////////////
  // Calibration and integration registers.
  //////////////////////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      cal_busy <= 1'b0;
      cal_cnt  <= '0;
      cal_sum  <= '0;
      offset   <= '0;                               // Uncalibrated until strt_cal.
      acc      <= '0;
      heading  <= '0;
      rdy      <= 1'b0;
      cal_done <= 1'b0;
    end else begin
      rdy      <= 1'b0;                             // Both are single-cycle pulses.
      cal_done <= 1'b0;
      if (strt_cal) begin                           // A sample landing in this cycle is dropped.
        cal_busy <= 1'b1;
        cal_cnt  <= '0;
        cal_sum  <= '0;
      end else if (vld && cal_busy) begin
        cal_cnt <= cal_cnt + 1'b1;
        cal_sum <= cal_sum_nxt;
        if (cal_last) begin
          cal_busy <= 1'b0;
          offset   <= cal_sum_nxt[15+CAL_W:CAL_W];  // Arithmetic shift gives the mean.
          acc      <= '0;                           // New reference direction.
          heading  <= '0;
          cal_done <= 1'b1;
        end
      end else if (vld) begin
        acc     <= acc_nxt;
        heading <= acc_nxt[HS+11:HS];               // Shifted and truncated to 12 bits.
        rdy     <= 1'b1;                            // Heading and rdy land together.
      end
    end
  end

endmodule

//--- design/inert_top.sv
`timescale 1ns/1ps

module inert_top import inert_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     strt_cal,  // Opens a calibration window.
  input  logic     moving,    // Integrate the rate only while driving.
  input  logic     lftIR,     // Left guardrail hit.
  input  logic     rghtIR,    // Right guardrail hit.
  input  logic     MISO,
  input  logic     INT,       // Sensor data-ready, asynchronous.
  output logic     SS_n,
  output logic     SCLK,
  output logic     MOSI,
  output logic     cal_done,
  output logic     rdy,
  output heading_t heading
);

  spi_bus_if spi_bus ();      // Sequencer to SPI master link.
  logic      vld;             // New yaw sample strobe.
  yaw_rate_t yaw_rt;          // Latest yaw sample.

  inert_seq u_seq (
    .clk    (clk),
    .rst_n  (rst_n),
    .INT    (INT),
    .bus    (spi_bus.seq),
    .vld    (vld),
    .yaw_rt (yaw_rt)
  );

  spi_mnrch u_spi (.clk(clk), .rst_n(rst_n), .bus(spi_bus.mstr),
                   .SS_n(SS_n), .SCLK(SCLK), .MOSI(MOSI), .MISO(MISO));

  yaw_integrator u_integ (
    .clk(clk), .rst_n(rst_n),
    .strt_cal (strt_cal),
    .vld      (vld),
    .yaw_rt   (yaw_rt),
    .moving   (moving),
    .lftIR    (lftIR),
    .rghtIR   (rghtIR),
    .cal_done (cal_done),
    .rdy      (rdy),
    .heading  (heading)
  );

endmodule

//--- verification/gyro_model.sv
`timescale 1ns/1ps

module gyro_model (
  input  logic        SS_n,
  input  logic        SCLK,
  input  logic        MOSI,
  output logic        MISO,
  output logic        INT,
  input  logic [15:0] yaw,         // Rate returned by the next pair of yaw reads.
  input  int          int_req,     // Running count of requested data-ready events.
  output logic [15:0] frame_word,  // Last complete frame seen on MOSI.
  output int          frame_cnt    // Frames completed since power-up.
);

  logic [15:0] rx_word;   // Bits collected on MOSI, MSB first.
  logic [15:0] tx_word;   // Response for the frame in flight.
  logic [15:0] tx_view;   // Response moved along by the falls seen so far.
  int          fall_cnt;  // SCLK falls in this frame.
  int          rise_cnt;  // SCLK rises in this frame.
  int          served;    // Samples whose low byte has been read.

  assign tx_view = tx_word << fall_cnt;     // Next bit always sits at the top.
  assign MISO    = tx_view[15];
  assign INT     = (int_req != served);     // Data ready until the low byte is read.

  //////////////////////////////////////////////////
  // Mode 0 slave, one frame per select low period.
  //////////////////////////////////////////////////
  initial begin
    rx_word    = '0;
    tx_word    = '0;
    fall_cnt   = 0;
    rise_cnt   = 0;
    served     = 0;
    frame_word = '0;
    frame_cnt  = 0;
    forever begin
      @(negedge SS_n);                      // Frame starts.
      rise_cnt = 0;
      fall_cnt = 0;
      tx_word  = '0;                        // Command byte phase returns zeros.
      while (!SS_n) begin
        @(SCLK or SS_n);
        if (!SS_n && SCLK) begin
          rx_word = {rx_word[14:0], MOSI};  // MOSI is stable on the rising edge.
          rise_cnt++;
          if (rise_cnt == 8 && rx_word[7:0] == 8'hA7) begin
            tx_word = {8'h00, yaw[15:8]};   // Yaw high register.
          end else if (rise_cnt == 8 && rx_word[7:0] == 8'hA6) begin
            tx_word = {8'h00, yaw[7:0]};    // Yaw low register.
            served++;                       // Reading the low byte clears INT.
          end
        end else if (!SS_n) begin
          fall_cnt++;                       // MISO moves on to the next bit.
        end
      end
      frame_word = rx_word;                 // Select went high, the frame is complete.
      frame_cnt++;
    end
  end

endmodule

//--- verification/inert_props.sv
`timescale 1ns/1ps

module inert_props (
  input logic clk,
  input logic rst_n,
  input logic vld,       // Sample strobe into the integrator.
  input logic rdy,       // Integrator heading strobe.
  input logic cal_done,  // Integrator calibration strobe.
  input logic SS_n,      // SPI master select.
  input logic SCLK       // SPI master clock.
);

  //////////////////////////////////////////////////
  // Integrator strobes.
  //////////////////////////////////////////////////
  rdy_single: assert property (@(posedge clk) disable iff (!rst_n) rdy |=> !rdy)
    else $error("rdy stayed high for more than one cycle");

  cal_done_single: assert property (@(posedge clk) disable iff (!rst_n) cal_done |=> !cal_done)
    else $error("cal_done stayed high for more than one cycle");

  rdy_after_vld: assert property (@(posedge clk) disable iff (!rst_n) rdy |-> $past(vld))
    else $error("rdy rose without a vld in the cycle before");

  //////////////////////////////////////////////////
  // SPI master pins.
  //////////////////////////////////////////////////
  sclk_idle: assert property (@(posedge clk) disable iff (!rst_n) SS_n |-> !SCLK)
    else $error("SCLK high while SS_n is high");

endmodule

// Observes the integrator strobes and the SPI pins where they meet at the top level.
bind inert_top inert_props props0 (.clk(clk), .rst_n(rst_n), .vld(vld), .rdy(rdy),
                                   .cal_done(cal_done), .SS_n(SS_n), .SCLK(SCLK));

//--- verification/inert_tb.sv
`timescale 1ns/1ps
`include "inert_cfg.svh"

module inert_tb import inert_pkg::*; ();

  localparam int CAL_N      = 1 << `CAL_SAMPLES_LOG2;  // Samples in a calibration window.
  localparam int WAIT_LIMIT = 2000;                   // Cycles allowed for any one wait.

  logic        clk = 1'b0;
  logic        rst_n;
  logic        strt_cal;
  logic        moving;
  logic        lftIR;
  logic        rghtIR;
  logic        MISO;
  logic        INT;
  logic        SS_n;
  logic        SCLK;
  logic        MOSI;
  logic        cal_done;
  logic        rdy;
  heading_t    heading;
  logic [15:0] yaw_val;     // Rate the sensor reports for the next sample.
  int          int_req;     // Each increment raises INT once.
  spi_word_t   frame_word;  // Last frame the sensor received.
  int          frame_cnt;

  spi_word_t          frames[$];   // Every frame the sensor received in arrival order.
  int                 cal_pulses;  // cal_done pulses seen so far.
  int                 rdy_pulses;  // rdy pulses seen so far.
  int                 err_cnt;     // Failed checks over the whole run.
  int                 test_err;    // Failed checks in the current test.
  int                 tests_run;
  int                 tests_bad;
  bit                 aborted;     // A wait ran out or the data file was missing.
  logic signed [23:0] acc_ref;     // Reference accumulator with the integrator's 24-bit width.
  int                 offset_ref;  // Reference gyro bias.
  int                 cal_sum_ref;
  int                 prev_head;   // Heading after the previous sample.

  always #4 clk = ~clk;            // 8 ns period.

  inert_top dut0 (
    .clk(clk), .rst_n(rst_n), .strt_cal(strt_cal), .moving(moving),
    .lftIR(lftIR), .rghtIR(rghtIR), .MISO(MISO), .INT(INT),
    .SS_n(SS_n), .SCLK(SCLK), .MOSI(MOSI), .cal_done(cal_done),
    .rdy(rdy), .heading(heading)
  );

  gyro_model sensor0 (
    .SS_n(SS_n), .SCLK(SCLK), .MOSI(MOSI), .MISO(MISO), .INT(INT),
    .yaw(yaw_val), .int_req(int_req), .frame_word(frame_word), .frame_cnt(frame_cnt)
  );

  always @(frame_cnt) begin
    if (frame_cnt > frames.size())
      frames.push_back(frame_word);  // Log each frame as the sensor finishes it.
  end

  always @(posedge clk) begin
    if (cal_done)
      cal_pulses <= cal_pulses + 1;
    if (rdy)
      rdy_pulses <= rdy_pulses + 1;  // Calibration samples must not add to this.
  end

  //////////////////////////////////////////////////
  // Checks and reporting.
  //////////////////////////////////////////////////
  task automatic check_value(input string sig, input int got, input int exp);
    assert (got == exp) else begin
      $display("[FAIL] t=%0t %s: got %0d, expected %0d", $time, sig, got, exp);
      err_cnt++;
      test_err++;
    end
  endtask

  task automatic check_word(input string sig, input spi_word_t got, input spi_word_t exp);
    assert (got == exp) else begin
      $display("[FAIL] t=%0t %s: got 0x%h, expected 0x%h", $time, sig, got, exp);
      err_cnt++;
      test_err++;
    end
  endtask

  task automatic report_test(input string name);
    tests_run++;
    if (test_err == 0) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_bad++;
      $display("test %0d %s: %0d mismatches", tests_run, name, test_err);
    end
    test_err = 0;
  endtask

  //////////////////////////////////////////////////
  // Bounded waits.
  //////////////////////////////////////////////////
  task automatic wait_frames(input int n, output bit ok);
    int cyc;
    ok = 1'b0;
    for (cyc = 0; cyc < WAIT_LIMIT && !ok; cyc++) begin
      @(posedge clk);
      ok = (frames.size() >= n);
    end
  endtask

  task automatic wait_pulse(input bit for_cal, output bit ok);
    int cyc;
    ok = 1'b0;
    for (cyc = 0; cyc < WAIT_LIMIT && !ok; cyc++) begin
      @(posedge clk);
      ok = for_cal ? cal_done : rdy;  // Heading is valid in the same cycle as rdy.
    end
  endtask

  //////////////////////////////////////////////////
  // One sample is driven, signalled on INT, awaited and compared.
  //////////////////////////////////////////////////
  task automatic run_sample(input int idx, input int rate, input int mov, input int lft,
                            input int rgt, input int exp_file, output bit ok);
    int base;
    int exp_head;
    bit is_cal;
    bit last_cal;
    base     = frames.size();
    is_cal   = (idx < CAL_N);
    last_cal = (idx == CAL_N - 1);
    @(posedge clk);
    yaw_val <= 16'(rate);
    moving  <= (mov != 0);
    lftIR   <= (lft != 0);
    rghtIR  <= (rgt != 0);
    @(posedge clk);
    int_req <= int_req + 1;                   // Sensor signals a new sample.
    if (is_cal && !last_cal)
      wait_frames(base + 2, ok);              // Calibration samples give no rdy.
    else
      wait_pulse(last_cal, ok);
    if (!ok) begin
      $display("Timeout: sample %0d never completed its yaw reads.", idx);
      return;
    end
    check_value("frames per sample", frames.size() - base, 2);
    if (frames.size() >= base + 2) begin
      check_word("yaw high read", frames[base], 16'hA700);
      check_word("yaw low read", frames[base + 1], 16'hA600);
    end
    if (is_cal) begin
      cal_sum_ref += rate;
      if (last_cal) begin
        offset_ref = cal_sum_ref >>> `CAL_SAMPLES_LOG2;  // Mean of the window.
        acc_ref    = '0;
        prev_head  = 0;
        check_value("heading", int'(heading), 0);
      end
    end else begin
      if (mov != 0)
        acc_ref = acc_ref + 24'(rate - offset_ref);
      if (lft != 0)
        acc_ref = acc_ref + 24'(`IR_CORR);    // Left guardrail turns one way.
      if (rgt != 0)
        acc_ref = acc_ref - 24'(`IR_CORR);    // Right guardrail turns the other.
      exp_head = int'(heading_t'(acc_ref >>> `HEAD_SHIFT));
      check_value("heading", int'(heading), exp_head);
      check_value("expected column", exp_file, exp_head);
      if (mov == 0 && lft == 0 && rgt == 0)
        check_value("heading hold", int'(heading), prev_head);
      prev_head = exp_head;
    end
    report_test($sformatf("sample %0d", idx));
  endtask

  task automatic run_tests();
    bit    ok;
    int    fd;
    int    code;
    int    n_data;
    string line;
    int    rate;
    int    mov;
    int    lft;
    int    rgt;
    int    exp_file;
    wait_frames(3, ok);                       // Boot wait plus three configuration frames.
    if (!ok) begin
      $display("Timeout: the configuration words never reached the sensor.");
      aborted = 1'b1;
      return;
    end
    check_word("config frame 0", frames[0], 16'h0D02);
    check_word("config frame 1", frames[1], 16'h1160);
    check_word("config frame 2", frames[2], 16'h1440);
    report_test("boot configuration");
    @(posedge clk);
    strt_cal <= 1'b1;
    @(posedge clk);
    strt_cal <= 1'b0;
    fd = $fopen("verification/inert_testdata.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file.");
      aborted = 1'b1;
      return;
    end
    n_data = 0;
    while (!$feof(fd)) begin
      code = $fgets(line, fd);
      if (code == 0 || line.len() < 2 || line.substr(0, 1) == "//")
        continue;                             // Blank and comment lines.
      code = $sscanf(line, "%d %d %d %d %d", rate, mov, lft, rgt, exp_file);
      if (code != 5)
        continue;
      run_sample(n_data, rate, mov, lft, rgt, exp_file, ok);
      if (!ok) begin
        $fclose(fd);
        aborted = 1'b1;
        return;
      end
      n_data++;
    end
    $fclose(fd);
    @(posedge clk);
    check_value("cal_done pulses", cal_pulses, 1);
    check_value("rdy pulses", rdy_pulses, n_data - CAL_N);
    report_test("strobe counts");
  endtask

  initial begin
    rst_n       = 1'b1;
    strt_cal    = 1'b0;
    moving      = 1'b0;
    lftIR       = 1'b0;
    rghtIR      = 1'b0;
    yaw_val     = '0;
    int_req     = 0;
    cal_pulses  = 0;
    rdy_pulses  = 0;
    err_cnt     = 0;
    test_err    = 0;
    tests_run   = 0;
    tests_bad   = 0;
    aborted     = 1'b0;
    acc_ref     = '0;
    offset_ref  = 0;
    cal_sum_ref = 0;
    prev_head   = 0;
    #1 rst_n = 1'b0;                          // Falling edge fires the asynchronous resets.
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    run_tests();
    $display("%0d tests run, %0d with mismatches, %0d check errors",
             tests_run, tests_bad, err_cnt);
    if (err_cnt == 0 && tests_bad == 0 && !aborted)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

//--- verification/inert_testdata.txt
// yaw_rate moving lftIR rghtIR expected_heading, one sample per line, decimal.
// The first 8 lines are the calibration window and their heading column is unused.
40 0 0 0 0
40 0 0 0 0
40 0 0 0 0
40 0 0 0 0
40 0 0 0 0
40 0 0 0 0
40 0 0 0 0
40 0 0 0 0
40 1 0 0 0
1064 1 0 0 4
2088 1 0 0 12
5000 0 0 0 12
-3000 0 0 0 12
40 1 1 0 14
40 1 0 1 12
-6104 1 0 0 -12
40 0 0 1 -14
-1000 1 1 1 -19

//--- sources.f
+incdir+design
design/inert_pkg.sv
design/spi_bus_if.sv
design/spi_mnrch.sv
design/inert_seq.sv
design/yaw_integrator.sv
design/inert_top.sv
verification/gyro_model.sv
verification/inert_props.sv
verification/inert_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= inert_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= tests failed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG) || [ $$status -ne 0 ]; then \
	  echo "Simulation reported a failure."; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
